// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = executeSliceTb
FILELIST = list.f
OBJDIR   = obj_dir
PASSMSG  = ** PASS **

.PHONY: lint sim clean

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

# Pass is decided by the pass line in the simulator output
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASSMSG)'

clean:
	rm -rf $(OBJDIR)

// ==== list.f ====
logic/coreDecodePkg.sv
logic/mainController.sv
logic/arithmeticLogicUnit.sv
logic/branchResolver.sv
logic/loadStoreAligner.sv
logic/resultRegister.sv
logic/executeSlice.sv
testbench/executeSlice_chk.sv
testbench/executeSliceTb.sv

// ==== logic/arithmeticLogicUnit.sv ====
`timescale 1ns/1ps

module arithmeticLogicUnit (
	input  coreDecodePkg::instrWord instr,
	input  logic [31:0]             rsValue,
	input  logic [31:0]             rtValue,
	input  coreDecodePkg::aluOp     aluOp,
	input  coreDecodePkg::extMode   extMode,
	input  logic                    aluBSel,
	output logic [31:0]             aluResult
);

	logic [15:0] immediate;
	logic [31:0] extImmediate;
	logic [31:0] operandB;
	logic [4:0]  shiftAmount;
	logic [4:0]  varAmount;

	assign immediate = instr.iType.immediate;

	// Immediate extension
	always_comb
	begin
		case (extMode)
			coreDecodePkg::extSign:  extImmediate = {{16{immediate[15]}}, immediate};
			coreDecodePkg::extUpper: extImmediate = {immediate, 16'h0000};
			default:                 extImmediate = {16'h0000, immediate};
		endcase
	end

	assign operandB = aluBSel ? extImmediate : rtValue;

	assign shiftAmount = instr.rType.shamt;
	assign varAmount   = rsValue[4:0];

	////////////////////////////////////////////////////////////
	// Operation select
	////////////////////////////////////////////////////////////
	always_comb
	begin
		case (aluOp)
			coreDecodePkg::aluAdd:   aluResult = rsValue + operandB;
			coreDecodePkg::aluSub:   aluResult = rsValue - operandB;
			coreDecodePkg::aluAnd:   aluResult = rsValue & operandB;
			coreDecodePkg::aluOr:    aluResult = rsValue | operandB;
			coreDecodePkg::aluXor:   aluResult = rsValue ^ operandB;
			coreDecodePkg::aluNor:   aluResult = ~(rsValue | operandB);
			coreDecodePkg::aluSll:   aluResult = operandB << shiftAmount;
			coreDecodePkg::aluSrl:   aluResult = operandB >> shiftAmount;
			coreDecodePkg::aluSra:   aluResult = $signed(operandB) >>> shiftAmount;
			coreDecodePkg::aluSllv:  aluResult = operandB << varAmount;
			coreDecodePkg::aluSrlv:  aluResult = operandB >> varAmount;
			coreDecodePkg::aluSrav:  aluResult = $signed(operandB) >>> varAmount;
			coreDecodePkg::aluLt:
				aluResult = {31'd0, $signed(rsValue) < $signed(operandB)};
			coreDecodePkg::aluLtu:   aluResult = {31'd0, rsValue < operandB};
			// LUI, immediate already in the upper half
			coreDecodePkg::aluPassB: aluResult = operandB;
			default:                 aluResult = 32'd0;
		endcase
	end

endmodule

// ==== logic/branchResolver.sv ====
`timescale 1ns/1ps

module branchResolver (
	input  coreDecodePkg::instrWord  instr,
	input  logic [31:0]              rsValue,
	input  logic [31:0]              rtValue,
	input  logic [31:0]              pc,
	input  coreDecodePkg::branchKind branchKind,
	input  logic                     jump,
	input  logic                     jumpReg,
	output logic [31:0]              nextPc,
	output logic [31:0]              linkAddress,
	output logic                     branchTaken
);

	logic [31:0] pcPlus4;
	logic [31:0] branchTarget;
	logic [31:0] jumpTarget;
	logic        condTaken;

	assign pcPlus4      = pc + 32'd4;
	assign branchTarget = pcPlus4 + {{14{instr.iType.immediate[15]}}, instr.iType.immediate, 2'b00};
	// Stays inside the current 256 MB region
	assign jumpTarget   = {pcPlus4[31:28], instr.jType.index, 2'b00};
	assign linkAddress  = pc + 32'd8;

	always_comb
	begin
		case (branchKind)
			coreDecodePkg::brEq:  condTaken = (rsValue == rtValue);
			coreDecodePkg::brNe:  condTaken = (rsValue != rtValue);
			coreDecodePkg::brLez: condTaken = rsValue[31] | (rsValue == 32'd0);
			coreDecodePkg::brGtz: condTaken = ~rsValue[31] & (rsValue != 32'd0);
			coreDecodePkg::brLtz: condTaken = rsValue[31];
			coreDecodePkg::brGez: condTaken = ~rsValue[31];
			default:              condTaken = 1'b0;
		endcase
	end

	// Jumps take priority over the condition path
	always_comb
	begin
		if (jump)
			nextPc = jumpReg ? rsValue : jumpTarget;
		else if (condTaken)
			nextPc = branchTarget;
		else
			nextPc = pcPlus4;
	end

	assign branchTaken = jump | condTaken;

endmodule

// ==== logic/coreDecodePkg.sv ====
package coreDecodePkg;

	////////////////////////////////////////////////////////////
	// Opcode field
	////////////////////////////////////////////////////////////
	localparam logic [5:0] opcodeSpecial = 6'h00;
	localparam logic [5:0] opcodeRegimm  = 6'h01;
	localparam logic [5:0] opcodeJ       = 6'h02;
	localparam logic [5:0] opcodeJal     = 6'h03;
	localparam logic [5:0] opcodeBeq     = 6'h04;
	localparam logic [5:0] opcodeBne     = 6'h05;
	localparam logic [5:0] opcodeBlez    = 6'h06;
	localparam logic [5:0] opcodeBgtz    = 6'h07;
	localparam logic [5:0] opcodeAddi    = 6'h08;
	localparam logic [5:0] opcodeAddiu   = 6'h09;
	localparam logic [5:0] opcodeSlti    = 6'h0a;
	localparam logic [5:0] opcodeSltiu   = 6'h0b;
	localparam logic [5:0] opcodeAndi    = 6'h0c;
	localparam logic [5:0] opcodeOri     = 6'h0d;
	localparam logic [5:0] opcodeXori    = 6'h0e;
	localparam logic [5:0] opcodeLui     = 6'h0f;
	localparam logic [5:0] opcodeLb      = 6'h20;
	localparam logic [5:0] opcodeLh      = 6'h21;
	localparam logic [5:0] opcodeLw      = 6'h23;
	localparam logic [5:0] opcodeLbu     = 6'h24;
	localparam logic [5:0] opcodeLhu     = 6'h25;
	localparam logic [5:0] opcodeSb      = 6'h28;
	localparam logic [5:0] opcodeSh      = 6'h29;
	localparam logic [5:0] opcodeSw      = 6'h2b;

	// Funct field under SPECIAL
	localparam logic [5:0] functSll  = 6'h00;
	localparam logic [5:0] functSrl  = 6'h02;
	localparam logic [5:0] functSra  = 6'h03;
	localparam logic [5:0] functSllv = 6'h04;
	localparam logic [5:0] functSrlv = 6'h06;
	localparam logic [5:0] functSrav = 6'h07;
	localparam logic [5:0] functJr   = 6'h08;
	localparam logic [5:0] functJalr = 6'h09;
	localparam logic [5:0] functAdd  = 6'h20;
	localparam logic [5:0] functAddu = 6'h21;
	localparam logic [5:0] functSub  = 6'h22;
	localparam logic [5:0] functSubu = 6'h23;
	localparam logic [5:0] functAnd  = 6'h24;
	localparam logic [5:0] functOr   = 6'h25;
	localparam logic [5:0] functXor  = 6'h26;
	localparam logic [5:0] functNor  = 6'h27;
	localparam logic [5:0] functSlt  = 6'h2a;
	localparam logic [5:0] functSltu = 6'h2b;

	// Rt field under REGIMM
	localparam logic [4:0] rtBltz = 5'h00;
	localparam logic [4:0] rtBgez = 5'h01;

	////////////////////////////////////////////////////////////
	// Datapath control codes
	////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
		aluSll, aluSrl, aluSra, aluSllv, aluSrlv, aluSrav,
		aluLt, aluLtu, aluPassB
	} aluOp;

	typedef enum logic [1:0] {extZero, extSign, extUpper} extMode;

	typedef enum logic [2:0] {
		accNone, accByte, accByteU, accHalf, accHalfU, accWord
	} accessSize;

	typedef enum logic [1:0] {resAlu, resLink, resLoad} resultSel;

	typedef enum logic [2:0] {
		brNone, brEq, brNe, brLez, brGtz, brLtz, brGez
	} branchKind;

	// One instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rType;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] immediate;
		} iType;
		struct packed {
			logic [5:0]  opcode;
			logic [25:0] index;
		} jType;
	} instrWord;

endpackage

// ==== logic/executeSlice.sv ====
`timescale 1ns/1ps

module executeSlice (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    instrValid,
	input  coreDecodePkg::instrWord instr,
	input  logic [31:0]             rsValue,
	input  logic [31:0]             rtValue,
	input  logic [31:0]             pc,
	input  logic [31:0]             memReadWord,
	output logic                    resultValid,
	output logic [31:0]             result,
	output logic [4:0]              destReg,
	output logic                    regWrite,
	output logic                    memWrite,
	output logic [3:0]              byteEnable,
	output logic [31:0]             storeData,
	output logic [31:0]             nextPc,
	output logic                    branchTaken
);

	// Decoder controls
	coreDecodePkg::aluOp      aluOp;
	coreDecodePkg::extMode    extMode;
	coreDecodePkg::accessSize accessSize;
	coreDecodePkg::resultSel  resultSel;
	coreDecodePkg::branchKind branchKind;
	logic                     aluBSel;
	logic                     jump;
	logic                     jumpReg;
	logic                     decRegWrite;
	logic                     decMemWrite;
	logic [4:0]               decDestReg;

	// Datapath values ahead of the register
	logic [31:0] aluResult;
	logic [31:0] exNextPc;
	logic [31:0] linkAddress;
	logic        exBranchTaken;
	logic [3:0]  exByteEnable;
	logic [31:0] exStoreData;
	logic [31:0] loadValue;

	mainController controller (
		.instr      (instr),
		.aluOp      (aluOp),
		.extMode    (extMode),
		.aluBSel    (aluBSel),
		.accessSize (accessSize),
		.resultSel  (resultSel),
		.branchKind (branchKind),
		.jump       (jump),
		.jumpReg    (jumpReg),
		.regWrite   (decRegWrite),
		.memWrite   (decMemWrite),
		.destReg    (decDestReg)
	);

	arithmeticLogicUnit alu (
		.instr     (instr),
		.rsValue   (rsValue),
		.rtValue   (rtValue),
		.aluOp     (aluOp),
		.extMode   (extMode),
		.aluBSel   (aluBSel),
		.aluResult (aluResult)
	);

	branchResolver branch (
		.instr       (instr),
		.rsValue     (rsValue),
		.rtValue     (rtValue),
		.pc          (pc),
		.branchKind  (branchKind),
		.jump        (jump),
		.jumpReg     (jumpReg),
		.nextPc      (exNextPc),
		.linkAddress (linkAddress),
		.branchTaken (exBranchTaken)
	);

	////////////////////////////////////////////////////////////
	// Memory lanes and output stage
	////////////////////////////////////////////////////////////
	loadStoreAligner aligner (
		.address     (aluResult),
		.rtValue     (rtValue),
		.memReadWord (memReadWord),
		.accessSize  (accessSize),
		.memWrite    (decMemWrite),
		.byteEnable  (exByteEnable),
		.storeData   (exStoreData),
		.loadValue   (loadValue)
	);

	resultRegister outputStage (
		.clk            (clk),
		.reset          (reset),
		.instrValid     (instrValid),
		.resultSel      (resultSel),
		.aluResult      (aluResult),
		.linkAddress    (linkAddress),
		.loadValue      (loadValue),
		.destReg        (decDestReg),
		.regWrite       (decRegWrite),
		.memWrite       (decMemWrite),
		.byteEnable     (exByteEnable),
		.storeData      (exStoreData),
		.nextPc         (exNextPc),
		.branchTaken    (exBranchTaken),
		.resultValid    (resultValid),
		.result         (result),
		.destRegOut     (destReg),
		.regWriteOut    (regWrite),
		.memWriteOut    (memWrite),
		.byteEnableOut  (byteEnable),
		.storeDataOut   (storeData),
		.nextPcOut      (nextPc),
		.branchTakenOut (branchTaken)
	);

endmodule

// ==== logic/loadStoreAligner.sv ====
`timescale 1ns/1ps

module loadStoreAligner (
	input  logic [31:0]              address,
	input  logic [31:0]              rtValue,
	input  logic [31:0]              memReadWord,
	input  coreDecodePkg::accessSize accessSize,
	input  logic                     memWrite,
	output logic [3:0]               byteEnable,
	output logic [31:0]              storeData,
	output logic [31:0]              loadValue
);

	logic [1:0]  offset;
	logic [3:0]  laneMask;
	logic [31:0] shiftedWord;
	logic [7:0]  loadByte;
	logic [15:0] loadHalf;

	assign offset = address[1:0];

	////////////////////////////////////////////////////////////
	// Store side
	////////////////////////////////////////////////////////////
	always_comb
	begin
		case (accessSize)
			coreDecodePkg::accByte, coreDecodePkg::accByteU:
			begin
				laneMask  = 4'b0001 << offset;
				storeData = {4{rtValue[7:0]}};
			end
			coreDecodePkg::accHalf, coreDecodePkg::accHalfU:
			begin
				laneMask  = offset[1] ? 4'b1100 : 4'b0011;
				storeData = {2{rtValue[15:0]}};
			end
			coreDecodePkg::accWord:
			begin
				laneMask  = 4'b1111;
				storeData = rtValue;
			end
			default:
			begin
				laneMask  = 4'b0000;
				storeData = rtValue;
			end
		endcase
	end

	assign byteEnable = memWrite ? laneMask : 4'b0000;

	// Load side, little-endian lanes
	assign shiftedWord = memReadWord >> {offset, 3'b000};
	assign loadByte    = shiftedWord[7:0];
	assign loadHalf    = offset[1] ? memReadWord[31:16] : memReadWord[15:0];

	always_comb
	begin
		case (accessSize)
			coreDecodePkg::accByte:  loadValue = {{24{loadByte[7]}}, loadByte};
			coreDecodePkg::accByteU: loadValue = {24'd0, loadByte};
			coreDecodePkg::accHalf:  loadValue = {{16{loadHalf[15]}}, loadHalf};
			coreDecodePkg::accHalfU: loadValue = {16'd0, loadHalf};
			default:                 loadValue = memReadWord;
		endcase
	end

endmodule

// ==== logic/mainController.sv ====
`timescale 1ns/1ps

module mainController (
	input  coreDecodePkg::instrWord  instr,
	output coreDecodePkg::aluOp      aluOp,
	output coreDecodePkg::extMode    extMode,
	output logic                     aluBSel,
	output coreDecodePkg::accessSize accessSize,
	output coreDecodePkg::resultSel  resultSel,
	output coreDecodePkg::branchKind branchKind,
	output logic                     jump,
	output logic                     jumpReg,
	output logic                     regWrite,
	output logic                     memWrite,
	output logic [4:0]               destReg
);

	always_comb
	begin
		// Anything not listed below stays all-inactive
		aluOp      = coreDecodePkg::aluAdd;
		extMode    = coreDecodePkg::extZero;
		aluBSel    = 1'b0;
		accessSize = coreDecodePkg::accNone;
		resultSel  = coreDecodePkg::resAlu;
		branchKind = coreDecodePkg::brNone;
		jump       = 1'b0;
		jumpReg    = 1'b0;
		regWrite   = 1'b0;
		memWrite   = 1'b0;
		destReg    = 5'd0;

		case (instr.rType.opcode)
			coreDecodePkg::opcodeSpecial:
			begin
				destReg = instr.rType.rd;
				regWrite = 1'b1;
				case (instr.rType.funct)
					coreDecodePkg::functAdd,
					coreDecodePkg::functAddu: aluOp = coreDecodePkg::aluAdd;
					coreDecodePkg::functSub,
					coreDecodePkg::functSubu: aluOp = coreDecodePkg::aluSub;
					coreDecodePkg::functAnd:  aluOp = coreDecodePkg::aluAnd;
					coreDecodePkg::functOr:   aluOp = coreDecodePkg::aluOr;
					coreDecodePkg::functXor:  aluOp = coreDecodePkg::aluXor;
					coreDecodePkg::functNor:  aluOp = coreDecodePkg::aluNor;
					coreDecodePkg::functSll:  aluOp = coreDecodePkg::aluSll;
					coreDecodePkg::functSrl:  aluOp = coreDecodePkg::aluSrl;
					coreDecodePkg::functSra:  aluOp = coreDecodePkg::aluSra;
					coreDecodePkg::functSllv: aluOp = coreDecodePkg::aluSllv;
					coreDecodePkg::functSrlv: aluOp = coreDecodePkg::aluSrlv;
					coreDecodePkg::functSrav: aluOp = coreDecodePkg::aluSrav;
					coreDecodePkg::functSlt:  aluOp = coreDecodePkg::aluLt;
					coreDecodePkg::functSltu: aluOp = coreDecodePkg::aluLtu;
					coreDecodePkg::functJr:
					begin
						jump     = 1'b1;
						jumpReg  = 1'b1;
						regWrite = 1'b0;
						destReg  = 5'd0;
					end
					coreDecodePkg::functJalr:
					begin
						jump      = 1'b1;
						jumpReg   = 1'b1;
						resultSel = coreDecodePkg::resLink;
					end
					// MULT, DIV, MFHI and friends land here
					default:
					begin
						regWrite = 1'b0;
						destReg  = 5'd0;
					end
				endcase
			end

			////////////////////////////////////////////////////////////
			// Immediate arithmetic and logic
			////////////////////////////////////////////////////////////
			coreDecodePkg::opcodeAddi, coreDecodePkg::opcodeAddiu,
			coreDecodePkg::opcodeSlti, coreDecodePkg::opcodeSltiu,
			coreDecodePkg::opcodeAndi, coreDecodePkg::opcodeOri,
			coreDecodePkg::opcodeXori, coreDecodePkg::opcodeLui:
			begin
				aluBSel  = 1'b1;
				regWrite = 1'b1;
				destReg  = instr.rType.rt;
				case (instr.rType.opcode)
					coreDecodePkg::opcodeSlti:  aluOp = coreDecodePkg::aluLt;
					coreDecodePkg::opcodeSltiu: aluOp = coreDecodePkg::aluLtu;
					coreDecodePkg::opcodeAndi:  aluOp = coreDecodePkg::aluAnd;
					coreDecodePkg::opcodeOri:   aluOp = coreDecodePkg::aluOr;
					coreDecodePkg::opcodeXori:  aluOp = coreDecodePkg::aluXor;
					coreDecodePkg::opcodeLui:   aluOp = coreDecodePkg::aluPassB;
					default:                    aluOp = coreDecodePkg::aluAdd;
				endcase
				case (instr.rType.opcode)
					coreDecodePkg::opcodeAndi, coreDecodePkg::opcodeOri,
					coreDecodePkg::opcodeXori: extMode = coreDecodePkg::extZero;
					coreDecodePkg::opcodeLui:  extMode = coreDecodePkg::extUpper;
					default:                   extMode = coreDecodePkg::extSign;
				endcase
			end

			// Loads and stores share the address adder
			coreDecodePkg::opcodeLb, coreDecodePkg::opcodeLbu,
			coreDecodePkg::opcodeLh, coreDecodePkg::opcodeLhu,
			coreDecodePkg::opcodeLw:
			begin
				extMode   = coreDecodePkg::extSign;
				aluBSel   = 1'b1;
				resultSel = coreDecodePkg::resLoad;
				regWrite  = 1'b1;
				destReg   = instr.rType.rt;
				case (instr.rType.opcode)
					coreDecodePkg::opcodeLb:  accessSize = coreDecodePkg::accByte;
					coreDecodePkg::opcodeLbu: accessSize = coreDecodePkg::accByteU;
					coreDecodePkg::opcodeLh:  accessSize = coreDecodePkg::accHalf;
					coreDecodePkg::opcodeLhu: accessSize = coreDecodePkg::accHalfU;
					default:                  accessSize = coreDecodePkg::accWord;
				endcase
			end
			coreDecodePkg::opcodeSb, coreDecodePkg::opcodeSh, coreDecodePkg::opcodeSw:
			begin
				extMode  = coreDecodePkg::extSign;
				aluBSel  = 1'b1;
				memWrite = 1'b1;
				case (instr.rType.opcode)
					coreDecodePkg::opcodeSb: accessSize = coreDecodePkg::accByte;
					coreDecodePkg::opcodeSh: accessSize = coreDecodePkg::accHalf;
					default:                 accessSize = coreDecodePkg::accWord;
				endcase
			end

			////////////////////////////////////////////////////////////
			// Branches and jumps
			////////////////////////////////////////////////////////////
			coreDecodePkg::opcodeBeq:  branchKind = coreDecodePkg::brEq;
			coreDecodePkg::opcodeBne:  branchKind = coreDecodePkg::brNe;
			coreDecodePkg::opcodeBlez: branchKind = coreDecodePkg::brLez;
			coreDecodePkg::opcodeBgtz: branchKind = coreDecodePkg::brGtz;
			coreDecodePkg::opcodeRegimm:
			begin
				case (instr.rType.rt)
					coreDecodePkg::rtBltz: branchKind = coreDecodePkg::brLtz;
					coreDecodePkg::rtBgez: branchKind = coreDecodePkg::brGez;
					default:               branchKind = coreDecodePkg::brNone;
				endcase
			end
			coreDecodePkg::opcodeJ:    jump = 1'b1;
			coreDecodePkg::opcodeJal:
			begin
				jump      = 1'b1;
				resultSel = coreDecodePkg::resLink;
				regWrite  = 1'b1;
				destReg   = 5'd31;
			end
			default:
			begin
				// COP0 and unknown opcodes
				jump = 1'b0;
			end
		endcase
	end

endmodule

// ==== logic/resultRegister.sv ====
`timescale 1ns/1ps

module resultRegister (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    instrValid,
	input  coreDecodePkg::resultSel resultSel,
	input  logic [31:0]             aluResult,
	input  logic [31:0]             linkAddress,
	input  logic [31:0]             loadValue,
	input  logic [4:0]              destReg,
	input  logic                    regWrite,
	input  logic                    memWrite,
	input  logic [3:0]              byteEnable,
	input  logic [31:0]             storeData,
	input  logic [31:0]             nextPc,
	input  logic                    branchTaken,
	output logic                    resultValid,
	output logic [31:0]             result,
	output logic [4:0]              destRegOut,
	output logic                    regWriteOut,
	output logic                    memWriteOut,
	output logic [3:0]              byteEnableOut,
	output logic [31:0]             storeDataOut,
	output logic [31:0]             nextPcOut,
	output logic                    branchTakenOut
);

	logic [31:0] writeBack;

	// Write-back source
	always_comb
	begin
		case (resultSel)
			coreDecodePkg::resLink: writeBack = linkAddress;
			coreDecodePkg::resLoad: writeBack = loadValue;
			default:                writeBack = aluResult;
		endcase
	end

	// Enables, cleared on idle cycles
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resultValid    <= 1'b0;
			regWriteOut    <= 1'b0;
			memWriteOut    <= 1'b0;
			byteEnableOut  <= 4'b0000;
			branchTakenOut <= 1'b0;
		end
		else
		begin
			resultValid    <= instrValid;
			regWriteOut    <= instrValid & regWrite;
			memWriteOut    <= instrValid & memWrite;
			byteEnableOut  <= instrValid ? byteEnable : 4'b0000;
			branchTakenOut <= instrValid & branchTaken;
		end
	end

	// Payload holds its value between strobes
	always_ff @(posedge clk)
	begin
		if (instrValid)
		begin
			result       <= writeBack;
			destRegOut   <= destReg;
			storeDataOut <= storeData;
			nextPcOut    <= nextPc;
		end
	end

endmodule

// ==== testbench/executeSliceTb.sv ====
`timescale 1ns/1ps

module executeSliceTb;

	// One trace line holds stimulus and expected outputs
	typedef struct {
		logic        valid;
		logic [31:0] instr;
		logic [31:0] rs;
		logic [31:0] rt;
		logic [31:0] pc;
		logic [31:0] mem;
		logic        expValid;
		logic [31:0] expResult;
		logic [4:0]  expDest;
		logic        expRegWrite;
		logic        expMemWrite;
		logic [3:0]  expByteEnable;
		logic [31:0] expStoreData;
		logic [31:0] expNextPc;
		logic        expTaken;
	} traceEntry;

	logic                    clk;
	logic                    reset;
	logic                    instrValid;
	coreDecodePkg::instrWord instr;
	logic [31:0]             rsValue;
	logic [31:0]             rtValue;
	logic [31:0]             pc;
	logic [31:0]             memReadWord;
	logic                    resultValid;
	logic [31:0]             result;
	logic [4:0]              destReg;
	logic                    regWrite;
	logic                    memWrite;
	logic [3:0]              byteEnable;
	logic [31:0]             storeData;
	logic [31:0]             nextPc;
	logic                    branchTaken;

	traceEntry entries[$];
	logic      traceLoaded;

	executeSlice DUT (
		.clk         (clk),
		.reset       (reset),
		.instrValid  (instrValid),
		.instr       (instr),
		.rsValue     (rsValue),
		.rtValue     (rtValue),
		.pc          (pc),
		.memReadWord (memReadWord),
		.resultValid (resultValid),
		.result      (result),
		.destReg     (destReg),
		.regWrite    (regWrite),
		.memWrite    (memWrite),
		.byteEnable  (byteEnable),
		.storeData   (storeData),
		.nextPc      (nextPc),
		.branchTaken (branchTaken)
	);

	bind executeSlice executeSlice_chk protocolChecks (
		.clk         (clk),
		.reset       (reset),
		.instrValid  (instrValid),
		.resultValid (resultValid),
		.regWrite    (regWrite),
		.memWrite    (memWrite),
		.byteEnable  (byteEnable),
		.branchTaken (branchTaken)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Failure reporting and compare tasks
	////////////////////////////////////////////////////////////
	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1, "Run aborted");
	endtask

	task automatic reportMismatch(input string field, input logic [31:0] got,
		input logic [31:0] exp);
		$display("FAIL at %0d ns: %s is %h, expected %h", $time, field, got, exp);
		abortRun("Stopped at the first mismatch");
	endtask

	task automatic checkFlag(input string field, input logic got, input logic exp);
		if (got !== exp)
			reportMismatch(field, {31'd0, got}, {31'd0, exp});
	endtask

	task automatic checkWord(input string field, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			reportMismatch(field, got, exp);
	endtask

	// Destination only matters while the write is enabled
	task automatic checkDest(input logic [4:0] gotDest, input logic gotWrite,
		input logic [4:0] expDest, input logic expWrite);
		checkFlag("regWrite", gotWrite, expWrite);
		if (expWrite && gotDest !== expDest)
			reportMismatch("destReg", {27'd0, gotDest}, {27'd0, expDest});
	endtask

	task automatic checkStore(input logic gotWrite, input logic [3:0] gotLanes,
		input logic [31:0] gotData, input logic expWrite, input logic [3:0] expLanes,
		input logic [31:0] expData);
		checkFlag("memWrite", gotWrite, expWrite);
		if (gotLanes !== expLanes)
			reportMismatch("byteEnable", {28'd0, gotLanes}, {28'd0, expLanes});
		if (expLanes != 4'b0000 && gotData !== expData)
			reportMismatch("storeData", gotData, expData);
	endtask

	task automatic checkFlow(input logic gotTaken, input logic [31:0] gotPc,
		input logic expTaken, input logic [31:0] expPc);
		checkFlag("branchTaken", gotTaken, expTaken);
		checkWord("nextPc", gotPc, expPc);
	endtask

	task automatic checkIdleOutputs();
		checkFlag("resultValid", resultValid, 1'b0);
		checkDest(destReg, regWrite, 5'd0, 1'b0);
		checkStore(memWrite, byteEnable, storeData, 1'b0, 4'b0000, 32'd0);
		checkFlag("branchTaken", branchTaken, 1'b0);
	endtask

	task automatic checkEntry(input traceEntry e);
		checkFlag("resultValid", resultValid, e.expValid);
		checkDest(destReg, regWrite, e.expDest, e.expRegWrite);
		if (e.expRegWrite)
			checkWord("result", result, e.expResult);
		checkStore(memWrite, byteEnable, storeData, e.expMemWrite, e.expByteEnable,
			e.expStoreData);
		if (e.expValid)
			checkFlow(branchTaken, nextPc, e.expTaken, e.expNextPc);
		else
			checkFlag("branchTaken", branchTaken, 1'b0);
	endtask

	task automatic driveEntry(input traceEntry e);
		instrValid  = e.valid;
		instr       = e.instr;
		rsValue     = e.rs;
		rtValue     = e.rt;
		pc          = e.pc;
		memReadWord = e.mem;
	endtask

	////////////////////////////////////////////////////////////
	// Trace file
	////////////////////////////////////////////////////////////
	task automatic loadTrace();
		int          fd;
		int          count;
		string       line;
		logic [31:0] col [15];
		traceEntry   e;
		fd = $fopen("testbench/executeSlice_trace.txt", "r");
		if (fd == 0)
			abortRun("Could not open testbench/executeSlice_trace.txt");
		while (!$feof(fd))
		begin
			count = $fgets(line, fd);
			if (count == 0 || line.getc(0) == "#")
				continue;
			count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
				col[8], col[9], col[10], col[11], col[12], col[13], col[14]);
			if (count == 15)
			begin
				e.valid         = col[0][0];
				e.instr         = col[1];
				e.rs            = col[2];
				e.rt            = col[3];
				e.pc            = col[4];
				e.mem           = col[5];
				e.expValid      = col[6][0];
				e.expResult     = col[7];
				e.expDest       = col[8][4:0];
				e.expRegWrite   = col[9][0];
				e.expMemWrite   = col[10][0];
				e.expByteEnable = col[11][3:0];
				e.expStoreData  = col[12];
				e.expNextPc     = col[13];
				e.expTaken      = col[14][0];
				entries.push_back(e);
			end
			else if (count > 0)
				abortRun($sformatf("Trace line has %0d fields instead of 15", count));
		end
		$fclose(fd);
	endtask

	// Limit scales with the trace length
	initial
	begin : watchdog
		int limitNs;
		wait (traceLoaded === 1'b1);
		limitNs = (entries.size() + 16 + 20) * 10;
		#(limitNs);
		abortRun($sformatf("Timeout: the run did not finish within %0d ns", limitNs));
	end

	// Stops at the first failed protocol assertion
	initial
	begin : assertionMonitor
		wait (DUT.protocolChecks.failCount != 0);
		abortRun("A protocol assertion in the bound checker failed");
	end

	initial
	begin : stimulus
		int index;
		traceLoaded = 1'b0;
		reset       = 1'b1;
		instrValid  = 1'b0;
		instr       = '0;
		rsValue     = 32'd0;
		rtValue     = 32'd0;
		pc          = 32'd0;
		memReadWord = 32'd0;
		loadTrace();
		traceLoaded = 1'b1;

		// Enables must read low on every cycle of reset
		repeat (16)
		begin
			@(posedge clk);
			@(negedge clk);
			checkIdleOutputs();
		end
		reset = 1'b0;

		// Check line index-1 while driving line index
		for (index = 0; index <= entries.size(); index++)
		begin
			if (index > 0)
				checkEntry(entries[index - 1]);
			if (index < entries.size())
				driveEntry(entries[index]);
			else
				instrValid = 1'b0;
			@(negedge clk);
		end

		if (DUT.protocolChecks.failCount == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== testbench/executeSlice_chk.sv ====
`timescale 1ns/1ps

module executeSlice_chk (
	input logic       clk,
	input logic       reset,
	input logic       instrValid,
	input logic       resultValid,
	input logic       regWrite,
	input logic       memWrite,
	input logic [3:0] byteEnable,
	input logic       branchTaken
);

	int failCount = 0;

	// One register stage between strobe and result
	validFollowsStrobe: assert property (@(posedge clk) disable iff (reset)
		resultValid == ($past(instrValid) && !$past(reset)))
	else
	begin
		failCount++;
		$error("resultValid does not follow instrValid by one cycle");
	end

	noDoubleWrite: assert property (@(posedge clk) disable iff (reset)
		!(regWrite && memWrite))
	else
	begin
		failCount++;
		$error("regWrite and memWrite high together");
	end

	lanesMatchStore: assert property (@(posedge clk) disable iff (reset)
		(byteEnable != 4'b0000) == memWrite)
	else
	begin
		failCount++;
		$error("byteEnable disagrees with memWrite");
	end

	////////////////////////////////////////////////////////////
	// Reset clears every enable
	////////////////////////////////////////////////////////////
	quietAfterReset: assert property (@(posedge clk)
		reset |=> (!resultValid && !regWrite && !memWrite && !branchTaken
			&& byteEnable == 4'b0000))
	else
	begin
		failCount++;
		$error("An enable is high in the cycle after reset");
	end

endmodule

// ==== testbench/executeSlice_trace.txt ====
# valid instr rsValue rtValue pc memReadWord | resultValid result destReg regWrite memWrite byteEnable storeData nextPc branchTaken
# all hex; result, destReg and storeData only compared when their enable is expected high
1 00221821 00000005 00000007 00400000 00000000 1 0000000c 03 1 0 0 00000000 00400004 0
1 00222022 00000005 00000007 00400004 00000000 1 fffffffe 04 1 0 0 00000000 00400008 0
1 00222824 f0f0ff00 0ff0f0f0 00400008 00000000 1 00f0f000 05 1 0 0 00000000 0040000c 0
1 00223027 f0f0ff00 0ff0f0f0 0040000c 00000000 1 000f000f 06 1 0 0 00000000 00400010 0
1 00023903 00000000 80000010 00400010 00000000 1 f8000001 07 1 0 0 00000000 00400014 0
1 00224006 00000024 80000010 00400014 00000000 1 08000001 08 1 0 0 00000000 00400018 0
1 0022482a ffffffff 00000001 00400018 00000000 1 00000001 09 1 0 0 00000000 0040001c 0
1 0022502b ffffffff 00000001 0040001c 00000000 1 00000000 0a 1 0 0 00000000 00400020 0
1 242bfffc 00000010 00000000 00400020 00000000 1 0000000c 0b 1 0 0 00000000 00400024 0
1 342c8001 12340000 00000000 00400024 00000000 1 12348001 0c 1 0 0 00000000 00400028 0
1 282dffff fffffffe 00000000 00400028 00000000 1 00000001 0d 1 0 0 00000000 0040002c 0
1 3c0ebeef 00000000 00000000 0040002c 00000000 1 beef0000 0e 1 0 0 00000000 00400030 0
0 00000000 00000000 00000000 00400030 00000000 0 00000000 00 0 0 0 00000000 00000000 0
1 a0220001 00001000 123456ab 00400034 00000000 1 00000000 00 0 1 2 abababab 00400038 0
1 a0220003 00001000 000000cd 00400038 00000000 1 00000000 00 0 1 8 cdcdcdcd 0040003c 0
1 a4220002 00001000 1234beef 0040003c 00000000 1 00000000 00 0 1 c beefbeef 00400040 0
1 ac22fffc 00001004 cafef00d 00400040 00000000 1 00000000 00 0 1 f cafef00d 00400044 0
1 80230002 00002000 00000000 00400044 4480ff22 1 ffffff80 03 1 0 0 00000000 00400048 0
1 90240003 00002000 00000000 00400048 9abcdef0 1 0000009a 04 1 0 0 00000000 0040004c 0
1 84250000 00002000 00000000 0040004c 1234f00d 1 fffff00d 05 1 0 0 00000000 00400050 0
1 94260002 00002000 00000000 00400050 87654321 1 00008765 06 1 0 0 00000000 00400054 0
1 8c270004 00002000 00000000 00400054 deadbeef 1 deadbeef 07 1 0 0 00000000 00400058 0
1 10220008 00000005 00000005 00400058 00000000 1 00000000 00 0 0 0 00000000 0040007c 1
1 1422fffe 00000005 00000005 0040005c 00000000 1 00000000 00 0 0 0 00000000 00400060 0
1 18200004 00000000 00000000 00400060 00000000 1 00000000 00 0 0 0 00000000 00400074 1
1 1c200004 00000000 00000000 00400064 00000000 1 00000000 00 0 0 0 00000000 00400068 0
1 0420fffc 80000000 00000000 00400068 00000000 1 00000000 00 0 0 0 00000000 0040005c 1
1 04210002 80000000 00000000 0040006c 00000000 1 00000000 00 0 0 0 00000000 00400070 0
1 08100040 00000000 00000000 00400070 00000000 1 00000000 00 0 0 0 00000000 00400100 1
1 0c100080 00000000 00000000 00400074 00000000 1 0040007c 1f 1 0 0 00000000 00400200 1
1 00200008 00400300 00000000 00400078 00000000 1 00000000 00 0 0 0 00000000 00400300 1
1 0020c809 00400400 00000000 0040007c 00000000 1 00400084 19 1 0 0 00000000 00400400 1
1 00220018 00000005 00000007 00400080 00000000 1 00000000 00 0 0 0 00000000 00400084 0
1 42000018 00000000 00000000 00400084 00000000 1 00000000 00 0 0 0 00000000 00400088 0
1 fc000000 00000000 00000000 00400088 00000000 1 00000000 00 0 0 0 00000000 0040008c 0
0 00000000 00000000 00000000 0040008c 00000000 0 00000000 00 0 0 0 00000000 00000000 0
